// ==== all.f ====
common/regman_pkg.sv
register_manager/register_manager.sv
register_manager/operand_sequencer.sv
verilog/bus_memory.sv
verilog/regman_top.sv
tests/regman_tb.sv

// ==== common/regman_pkg.sv ====
package regman_pkg;

  // bus widths
  localparam int addr_w = 16;
  localparam int data_w = 32;

  // data memory size, in words
  localparam int mem_depth = 256;
  localparam int mem_idx_w = $clog2(mem_depth);

  // register window of 16 words per process
  localparam int reg_num_w = 4;

  // request to done pulse, in cycles
  localparam int mem_latency = 2;
  localparam int lat_w = $clog2(mem_latency + 1);

  // register operations, one memory access each
  localparam int op_w = 3;
  localparam logic [op_w-1:0] op_none = 3'd0;
  // word at base_addr + reg_num
  localparam logic [op_w-1:0] op_read = 3'd1;
  // word at base_addr + pointer
  localparam logic [op_w-1:0] op_read_p = 3'd2;
  localparam logic [op_w-1:0] op_write = 3'd3;
  localparam logic [op_w-1:0] op_write_p = 3'd4;

  // pointer post-adjust flags
  localparam int flag_w = 2;
  localparam logic [flag_w-1:0] flag_none = 2'b00;
  localparam logic [flag_w-1:0] flag_inc = 2'b01;
  localparam logic [flag_w-1:0] flag_dec = 2'b10;

  // command kinds
  localparam logic cmd_load = 1'b0;
  localparam logic cmd_store = 1'b1;

endpackage

// ==== register_manager/operand_sequencer.sv ====
`timescale 1ns/1ps

module operand_sequencer import regman_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 cmd_kind,
  input  logic [reg_num_w-1:0] reg_num,
  input  logic                 is_ptr,
  input  logic [flag_w-1:0]    flags,
  input  logic [data_w-1:0]    store_data,
  input  logic [addr_w-1:0]    base_addr,
  input  logic                 op_done,
  input  logic [data_w-1:0]    op_data,
  output logic                 busy,
  output logic                 done,
  output logic [data_w-1:0]    operand,
  output logic [op_w-1:0]      reg_op,
  output logic                 op_start,
  output logic [reg_num_w-1:0] op_reg_num,
  output logic [data_w-1:0]    op_ptr,
  output logic [data_w-1:0]    op_wdata,
  output logic [addr_w-1:0]    op_base_addr
);

  // latched command fields
  logic              kind_q;
  logic              ptr_q;
  logic [flag_w-1:0] flags_q;
  logic [data_w-1:0] store_q;

  // next step
  logic              accept;
  logic              step;
  logic [op_w-1:0]   next_op;
  logic [data_w-1:0] next_wdata;
  logic              launch;
  logic              finish;

  // post-increment / post-decrement of a pointer value
  function automatic logic [data_w-1:0] adjust(input logic [data_w-1:0] value,
                                               input logic [flag_w-1:0] fl);
    logic [data_w-1:0] res;
    res = value;
    if (fl == flag_inc) begin
      res = value + 1'b1;
    end else if (fl == flag_dec) begin
      res = value - 1'b1;
    end
    return res;
  endfunction

  assign accept = start && !busy;
  assign step = busy && op_done;

  // walk the op order of load and store
  always_comb begin
    next_op = op_none;
    next_wdata = store_q;
    if (accept) begin
      // direct store is a single register write
      if (cmd_kind == cmd_store && !is_ptr) begin
        next_op = op_write;
      end else begin
        next_op = op_read;
      end
      next_wdata = store_data;
    end else if (step) begin
      case (reg_op)
        op_read: begin
          if (kind_q == cmd_store) begin
            // register holds the target pointer
            next_op = op_write_p;
          end else if (ptr_q) begin
            next_op = op_read_p;
          end else if (flags_q != flag_none) begin
            // plain register with post-adjust
            next_op = op_write;
            next_wdata = adjust(op_data, flags_q);
          end
        end
        op_read_p, op_write_p: begin
          // pointer write-back, if asked for
          if (flags_q != flag_none) begin
            next_op = op_write;
            next_wdata = adjust(op_ptr, flags_q);
          end
        end
        default: begin
          next_op = op_none;
        end
      endcase
    end
  end

  assign launch = next_op != op_none;
  assign finish = step && !launch;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      op_start <= 1'b0;
      reg_op <= op_none;
    end else begin
      op_start <= launch;
      done <= finish;
      if (accept) begin
        busy <= 1'b1;
      end else if (finish) begin
        busy <= 1'b0;
      end
      if (launch) begin
        reg_op <= next_op;
      end else if (finish) begin
        reg_op <= op_none;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      kind_q <= cmd_kind;
      ptr_q <= is_ptr;
      flags_q <= flags;
      store_q <= store_data;
      op_reg_num <= reg_num;
      op_base_addr <= base_addr;
      // a store reports its own data
      if (cmd_kind == cmd_store) begin
        operand <= store_data;
      end
    end
    if (launch) begin
      op_wdata <= next_wdata;
    end
    // keep the register word, it is the pointer for later steps
    if (step && reg_op == op_read) begin
      op_ptr <= op_data;
    end
    // load result is the pre-adjust word
    if (step && kind_q == cmd_load && (reg_op == op_read || reg_op == op_read_p)) begin
      operand <= op_data;
    end
  end

endmodule

// ==== register_manager/register_manager.sv ====
`timescale 1ns/1ps

module register_manager import regman_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [op_w-1:0]      reg_op,
  input  logic                 op_start,
  input  logic [reg_num_w-1:0] op_reg_num,
  input  logic [data_w-1:0]    op_ptr,
  input  logic [data_w-1:0]    op_wdata,
  input  logic [addr_w-1:0]    op_base_addr,
  input  logic                 mem_busy,
  input  logic                 read_dn,
  input  logic                 write_dn,
  input  logic [data_w-1:0]    rdata,
  output logic                 op_done,
  output logic [data_w-1:0]    op_data,
  output logic                 read_q,
  output logic                 write_q,
  output logic [addr_w-1:0]    mem_addr,
  output logic [data_w-1:0]    wdata
);

  // address candidates
  logic [addr_w-1:0] reg_addr;
  logic [addr_w-1:0] ptr_addr;

  // decode of the incoming op
  logic is_ptr_op;
  logic is_rd_op;
  logic is_wr_op;

  // request still to be put on the memory port
  logic issue_rd;
  logic issue_wr;

  // per-request waiting bits
  logic rd_wait;
  logic wr_wait;

  logic can_issue;
  logic rd_match;
  logic wr_match;

  // register word sits in the process window
  assign reg_addr = op_base_addr + addr_w'(op_reg_num);

  // pointer is relative to the same window, low bits only
  assign ptr_addr = op_base_addr + op_ptr[addr_w-1:0];

  assign is_ptr_op = (reg_op == op_read_p) || (reg_op == op_write_p);
  assign is_rd_op = (reg_op == op_read) || (reg_op == op_read_p);
  assign is_wr_op = (reg_op == op_write) || (reg_op == op_write_p);

  // one request at a time
  // memory gives no back-pressure other than mem_busy
  // the strobe terms cover the cycle before mem_busy rises
  assign can_issue = (issue_rd || issue_wr) && !mem_busy && !read_q && !write_q;

  // done kind has to match the request kind
  // a read_dn while a write is pending is dropped, and the reverse too
  assign rd_match = read_dn && rd_wait;
  assign wr_match = write_dn && wr_wait;

  always_ff @(posedge clk) begin
    if (rst) begin
      read_q <= 1'b0;
      write_q <= 1'b0;
      op_done <= 1'b0;
      issue_rd <= 1'b0;
      issue_wr <= 1'b0;
      rd_wait <= 1'b0;
      wr_wait <= 1'b0;
    end else begin
      // strobes last one cycle
      read_q <= 1'b0;
      write_q <= 1'b0;
      op_done <= 1'b0;

      if (op_start) begin
        issue_rd <= is_rd_op;
        issue_wr <= is_wr_op;
        // op_none touches no memory and finishes at once
        if (!is_rd_op && !is_wr_op) begin
          op_done <= 1'b1;
        end
      end

      // put the request out and arm its waiting bit
      if (can_issue) begin
        read_q <= issue_rd;
        write_q <= issue_wr;
        issue_rd <= 1'b0;
        issue_wr <= 1'b0;
        rd_wait <= issue_rd;
        wr_wait <= issue_wr;
      end

      // read came back from the register or pointer target
      if (rd_match) begin
        rd_wait <= 1'b0;
        op_done <= 1'b1;
      end

      // write acknowledged
      if (wr_match) begin
        wr_wait <= 1'b0;
        op_done <= 1'b1;
      end
    end
  end

  // address, write data and read value
  always_ff @(posedge clk) begin
    if (op_start) begin
      mem_addr <= is_ptr_op ? ptr_addr : reg_addr;
      wdata <= op_wdata;
    end
    // held until the next read completes
    if (rd_match) begin
      op_data <= rdata;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the regman testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module regman_tb -f all.f -o regman_sim

out=$(./obj_dir/regman_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// ==== tests/regman_golden.txt ====
# columns, all hex: cmd_kind reg_num is_ptr flags store_data base_addr expected check
# cmd_kind 0 load 1 store; flags 1 inc 2 dec; check 0 skips the operand compare
# direct store and load
1 3 0 0 deadbeef 0040 00000000 0
0 3 0 0 00000000 0040 deadbeef 1
# pointer in r5 aims at r9 of the same window
1 5 0 0 00000009 0040 00000000 0
1 9 0 0 12345678 0040 00000000 0
0 5 1 0 00000000 0040 12345678 1
0 5 0 0 00000000 0040 00000009 1
# post-increment and post-decrement through a pointer
1 a 0 0 cafef00d 0040 00000000 0
0 5 1 1 00000000 0040 12345678 1
0 5 0 0 00000000 0040 0000000a 1
0 5 1 0 00000000 0040 cafef00d 1
0 5 1 2 00000000 0040 cafef00d 1
0 5 0 0 00000000 0040 00000009 1
# adjust on a plain register returns the old value
0 5 0 1 00000000 0040 00000009 1
0 5 0 0 00000000 0040 0000000a 1
0 5 0 2 00000000 0040 0000000a 1
0 5 0 0 00000000 0040 00000009 1
# pointer store
1 5 1 0 0badf00d 0040 00000000 0
0 5 1 0 00000000 0040 0badf00d 1
0 9 0 0 00000000 0040 0badf00d 1
1 5 1 1 55aa55aa 0040 00000000 0
0 5 0 0 00000000 0040 0000000a 1
0 a 0 0 00000000 0040 cafef00d 1
0 9 0 0 00000000 0040 55aa55aa 1
1 5 1 2 0f0f0f0f 0040 00000000 0
0 5 0 0 00000000 0040 00000009 1
0 a 0 0 00000000 0040 0f0f0f0f 1
# two windows, same register numbers
1 3 0 0 11111111 0040 00000000 0
1 3 0 0 22222222 0080 00000000 0
0 3 0 0 00000000 0040 11111111 1
0 3 0 0 00000000 0080 22222222 1
1 2 0 0 33333333 0080 00000000 0
1 5 0 0 00000002 0080 00000000 0
0 5 1 0 00000000 0080 33333333 1
0 5 0 0 00000000 0040 00000009 1
0 5 1 0 00000000 0040 55aa55aa 1

// ==== tests/regman_tb.sv ====
`timescale 1ns/1ps

module regman_tb import regman_pkg::*; ();

  logic                 clk;
  logic                 rst;
  logic                 start;
  logic                 cmd_kind;
  logic [reg_num_w-1:0] reg_num;
  logic                 is_ptr;
  logic [flag_w-1:0]    flags;
  logic [data_w-1:0]    store_data;
  logic [addr_w-1:0]    base_addr;
  logic                 busy;
  logic                 done;
  logic [data_w-1:0]    operand;

  // error bookkeeping
  int checks;
  int commands;
  int mismatches;
  int failures;
  bit aborted;

  regman_top uut (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .cmd_kind   (cmd_kind),
    .reg_num    (reg_num),
    .is_ptr     (is_ptr),
    .flags      (flags),
    .store_data (store_data),
    .base_addr  (base_addr),
    .busy       (busy),
    .done       (done),
    .operand    (operand)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // poll at the falling edge, 200 cycles at most
  task automatic wait_idle(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < 200 && !ok; n++) begin
      @(negedge clk);
      if (!busy) ok = 1'b1;
    end
  endtask

  task automatic wait_done(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < 200 && !ok; n++) begin
      @(negedge clk);
      if (done) ok = 1'b1;
    end
  endtask

  // one command from start strobe to done pulse
  task automatic run_command(input int line_no, input logic kind,
                             input logic [reg_num_w-1:0] rnum, input logic ptr,
                             input logic [flag_w-1:0] fl, input logic [data_w-1:0] sdata,
                             input logic [addr_w-1:0] base, input logic [data_w-1:0] expected,
                             input logic chk);
    bit ok;
    wait_idle(ok);
    if (!ok) begin
      $display("timeout: DUT still busy before the command on line %0d", line_no);
      failures++;
      aborted = 1'b1;
    end else begin
      @(posedge clk);
      start <= 1'b1;
      cmd_kind <= kind;
      reg_num <= rnum;
      is_ptr <= ptr;
      flags <= fl;
      store_data <= sdata;
      base_addr <= base;
      @(posedge clk);
      start <= 1'b0;
      commands++;
      // accepted on this edge, busy has to be up now
      @(negedge clk);
      checks++;
      assert (busy) else begin
        $display("MISMATCH at %0t: busy low after start, line %0d", $time, line_no);
        mismatches++;
      end
      wait_done(ok);
      if (!ok) begin
        $display("timeout: no done pulse within 200 cycles for line %0d", line_no);
        failures++;
        aborted = 1'b1;
      end else begin
        checks++;
        assert (!busy) else begin
          $display("MISMATCH at %0t: busy still high at done, line %0d", $time, line_no);
          mismatches++;
        end
        // stores carry no operand to compare
        if (chk) begin
          checks++;
          assert (operand == expected) else begin
            $display("MISMATCH at %0t: line %0d operand %h, expected %h",
                     $time, line_no, operand, expected);
            mismatches++;
          end
        end
      end
    end
  endtask

  initial begin
    int                   fd;
    int                   fields;
    int                   line_no;
    string                line;
    logic                 f_kind;
    logic [reg_num_w-1:0] f_reg;
    logic                 f_ptr;
    logic [flag_w-1:0]    f_flags;
    logic [data_w-1:0]    f_data;
    logic [addr_w-1:0]    f_base;
    logic [data_w-1:0]    f_exp;
    logic                 f_chk;

    checks = 0;
    commands = 0;
    mismatches = 0;
    failures = 0;
    aborted = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    cmd_kind = cmd_load;
    reg_num = '0;
    is_ptr = 1'b0;
    flags = flag_none;
    store_data = '0;
    base_addr = '0;

    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // idle outputs right after reset
    @(negedge clk);
    checks += 2;
    assert (!busy) else begin
      $display("MISMATCH at %0t: busy high after reset", $time);
      mismatches++;
    end
    assert (!done) else begin
      $display("MISMATCH at %0t: done high after reset", $time);
      mismatches++;
    end

    fd = $fopen("tests/regman_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/regman_golden.txt");
      failures++;
    end else begin
      line_no = 0;
      while (!$feof(fd) && !aborted) begin
        line = "";
        fields = $fgets(line, fd);
        line_no++;
        // comment lines start with a hash
        if (line.len() > 0 && line[0] != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                           f_kind, f_reg, f_ptr, f_flags, f_data, f_base, f_exp, f_chk);
          if (fields == 8) begin
            run_command(line_no, f_kind, f_reg, f_ptr, f_flags, f_data, f_base,
                        f_exp, f_chk);
          end else if (fields > 0) begin
            $display("golden file line %0d has %0d fields instead of 8", line_no, fields);
            failures++;
          end
        end
      end
      $fclose(fd);
    end

    if (commands == 0) begin
      $display("no command was run from the golden file");
      failures++;
    end

    $display("commands %0d, checks %0d, mismatches %0d, other errors %0d",
             commands, checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== verilog/bus_memory.sv ====
`timescale 1ns/1ps

module bus_memory import regman_pkg::*; (
  input  logic              clk,
  input  logic              read_q,
  input  logic              write_q,
  input  logic [addr_w-1:0] mem_addr,
  input  logic [data_w-1:0] wdata,
  output logic              mem_busy,
  output logic              read_dn,
  output logic              write_dn,
  output logic [data_w-1:0] rdata
);

  logic [data_w-1:0] mem [mem_depth];

  // pending request
  logic [lat_w-1:0]     lat_cnt;
  logic                 pend_rd;
  logic                 pend_wr;
  logic [mem_idx_w-1:0] addr_q;
  logic [data_w-1:0]    wdata_q;

  logic req;
  logic last;

  assign req = (read_q || write_q) && !mem_busy;
  assign last = lat_cnt == lat_w'(1);

  assign mem_busy = lat_cnt != '0;
  assign read_dn = last && pend_rd;
  assign write_dn = last && pend_wr;

  // read sampled in the read_dn cycle
  assign rdata = mem[addr_q];

  // counts down from mem_latency, done pulse on the last count
  always_ff @(posedge clk) begin
    if (req) begin
      lat_cnt <= lat_w'(mem_latency);
      pend_rd <= read_q;
      // read wins if both strobes show up
      pend_wr <= write_q && !read_q;
    end else if (mem_busy) begin
      lat_cnt <= lat_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      addr_q <= mem_addr[mem_idx_w-1:0];
      wdata_q <= wdata;
    end
    // write lands together with write_dn
    if (write_dn) begin
      mem[addr_q] <= wdata_q;
    end
  end

endmodule

// ==== verilog/regman_top.sv ====
`timescale 1ns/1ps

module regman_top import regman_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 cmd_kind,
  input  logic [reg_num_w-1:0] reg_num,
  input  logic                 is_ptr,
  input  logic [flag_w-1:0]    flags,
  input  logic [data_w-1:0]    store_data,
  input  logic [addr_w-1:0]    base_addr,
  output logic                 busy,
  output logic                 done,
  output logic [data_w-1:0]    operand
);

  // sequencer to register manager
  logic [op_w-1:0]      reg_op;
  logic                 op_start;
  logic [reg_num_w-1:0] op_reg_num;
  logic [data_w-1:0]    op_ptr;
  logic [data_w-1:0]    op_wdata;
  logic [addr_w-1:0]    op_base_addr;
  logic                 op_done;
  logic [data_w-1:0]    op_data;

  // register manager to memory
  logic                 read_q;
  logic                 write_q;
  logic [addr_w-1:0]    mem_addr;
  logic [data_w-1:0]    wdata;
  logic                 mem_busy;
  logic                 read_dn;
  logic                 write_dn;
  logic [data_w-1:0]    rdata;

  operand_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .cmd_kind     (cmd_kind),
    .reg_num      (reg_num),
    .is_ptr       (is_ptr),
    .flags        (flags),
    .store_data   (store_data),
    .base_addr    (base_addr),
    .op_done      (op_done),
    .op_data      (op_data),
    .busy         (busy),
    .done         (done),
    .operand      (operand),
    .reg_op       (reg_op),
    .op_start     (op_start),
    .op_reg_num   (op_reg_num),
    .op_ptr       (op_ptr),
    .op_wdata     (op_wdata),
    .op_base_addr (op_base_addr)
  );

  register_manager u_rm (
    .clk          (clk),
    .rst          (rst),
    .reg_op       (reg_op),
    .op_start     (op_start),
    .op_reg_num   (op_reg_num),
    .op_ptr       (op_ptr),
    .op_wdata     (op_wdata),
    .op_base_addr (op_base_addr),
    .mem_busy     (mem_busy),
    .read_dn      (read_dn),
    .write_dn     (write_dn),
    .rdata        (rdata),
    .op_done      (op_done),
    .op_data      (op_data),
    .read_q       (read_q),
    .write_q      (write_q),
    .mem_addr     (mem_addr),
    .wdata        (wdata)
  );

  bus_memory u_mem (
    .clk      (clk),
    .read_q   (read_q),
    .write_q  (write_q),
    .mem_addr (mem_addr),
    .wdata    (wdata),
    .mem_busy (mem_busy),
    .read_dn  (read_dn),
    .write_dn (write_dn),
    .rdata    (rdata)
  );

endmodule
